//--- hw/serial_slave_defines.svh
// ####################
// sizes, timing and codes of the serial slave
// include wherever one of these values is needed
// ####################
`ifndef SERIAL_SLAVE_DEFINES_SVH
`define SERIAL_SLAVE_DEFINES_SVH

// memory geometry
`define SLAVE_MEM_DEPTH     2000
`define SLAVE_DATA_WIDTH    32
`define SLAVE_ADDR_WIDTH    11

// slave identity
`define SLAVE_ID_WIDTH      2
`define SLAVE_DEFAULT_ID    1

// idle cycles between frame decode and the first memory fetch
`define SLAVE_ACCESS_DELAY  2

// pattern that opens every command frame
`define SLAVE_START_CODE    3'b111

`endif

//--- hw/serial_slave_pkg.sv
// ####################
// types shared by the serial slave modules
// import inside a module body and use scoped names in headers
// ####################
`default_nettype none

`include "serial_slave_defines.svh"

package serial_slave_pkg;

    typedef logic [`SLAVE_DATA_WIDTH-1:0] data_word_t;
    typedef logic [`SLAVE_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [`SLAVE_ID_WIDTH-1:0]   slave_id_t;

    // command frame as it arrives on control with the first bit at the MSB
    typedef struct packed {
        logic [2:0] start_code;
        slave_id_t  slave_id;
        logic       write;
        logic       burst;
        word_addr_t addr;
    } cmd_frame_t;

    // one store into the word memory
    typedef struct packed {
        logic       en;
        word_addr_t addr;
        data_word_t data;
    } mem_write_t;

endpackage

`default_nettype wire

//--- hw/serial_deserializer.sv
// ####################
// serial to parallel shift register for any packed payload
// ####################
`timescale 1ns/10ps
`default_nettype none

module serial_deserializer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     shift_en,
    input  logic     bit_in,
    input  logic     clear,
    output payload_t payload,
    output logic     done
);

    localparam int W     = $bits(payload_t);
    localparam int CNT_W = (W > 1) ? $clog2(W) : 1;

    logic [W-1:0]     shift_q;
    logic [CNT_W-1:0] bit_cnt;
    logic             full;

    // last bit of the payload arrives on this shift
    assign full = shift_en && (bit_cnt == CNT_W'(W - 1));

    // first bit received ends up at the MSB
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift_q <= {shift_q[W-2:0], bit_in};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= full;
            if (clear) begin
                bit_cnt <= '0;
            end else if (full) begin
                bit_cnt <= '0;
            end else if (shift_en) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    assign payload = payload_t'(shift_q);

endmodule

`default_nettype wire

//--- hw/word_serializer.sv
// ####################
// parallel to serial shifter for read words, MSB first
// ####################
`timescale 1ns/10ps
`default_nettype none

module word_serializer (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         load,
    input  serial_slave_pkg::data_word_t word,
    input  logic                         shift_en,
    output logic                         bit_out,
    output logic                         word_done
);

    import serial_slave_pkg::*;

    localparam int W     = $bits(data_word_t);
    localparam int CNT_W = $clog2(W);

    data_word_t       data_q;
    logic [CNT_W-1:0] bit_cnt;

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= word;
        end else if (shift_en) begin
            data_q <= data_q << 1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt <= '0;
        end else if (load) begin
            bit_cnt <= '0;
        end else if (shift_en) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign bit_out = data_q[W-1];

    // high while the final bit of the word is on the line
    assign word_done = shift_en && (bit_cnt == CNT_W'(W - 1));

endmodule

`default_nettype wire

//--- hw/slave_memory.sv
// ####################
// word RAM with registered read and synchronous write
// ####################
`timescale 1ns/10ps
`default_nettype none

`include "serial_slave_defines.svh"

module slave_memory (
    input  logic                         clk,
    input  serial_slave_pkg::mem_write_t wr,
    input  serial_slave_pkg::word_addr_t rd_addr,
    output serial_slave_pkg::data_word_t rd_data
);

    import serial_slave_pkg::*;

    data_word_t ram [`SLAVE_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            ram[wr.addr] <= wr.data;
        end
        // read data one cycle after the address
        rd_data <= ram[rd_addr];
    end

endmodule

`default_nettype wire

//--- hw/slave_controller.sv
// ####################
// FSM of the serial slave for frame decode, access delay,
// read and write sequencing, burst addressing and ready
// ####################
`timescale 1ns/10ps
`default_nettype none

`include "serial_slave_defines.svh"

module slave_controller #(
    parameter serial_slave_pkg::slave_id_t SLAVE_ID = `SLAVE_DEFAULT_ID
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         control,
    input  logic                         valid,
    input  logic                         last,
    input  serial_slave_pkg::cmd_frame_t frame,
    input  logic                         frame_done,
    input  logic                         wr_done,
    input  logic                         word_done,
    input  serial_slave_pkg::data_word_t wr_word,
    output logic                         frame_shift,
    output logic                         frame_clear,
    output logic                         wr_shift,
    output logic                         rd_load,
    output logic                         rd_shift,
    output logic                         ready,
    output serial_slave_pkg::mem_write_t mem_wr,
    output serial_slave_pkg::word_addr_t rd_addr
);

    import serial_slave_pkg::*;

    localparam int DLY_W = $clog2(`SLAVE_ACCESS_DELAY + 1) + 1;
    localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(`SLAVE_ACCESS_DELAY - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FRAME,
        S_DELAY,
        S_FETCH,
        S_SEND,
        S_WRITE
    } state_t;

    state_t           state;
    logic [DLY_W-1:0] delay_cnt;
    word_addr_t       addr_q;
    logic             burst_q;
    // last seen during the current word
    logic             last_q;
    logic             frame_ok;

    assign frame_ok = (frame.start_code == `SLAVE_START_CODE) && (frame.slave_id == SLAVE_ID);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= S_IDLE;
            ready     <= 1'b1;
            delay_cnt <= '0;
            addr_q    <= '0;
            burst_q   <= 1'b0;
            last_q    <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    ready  <= 1'b1;
                    last_q <= 1'b0;
                    // first start bit already shifted on this edge
                    if (control) begin
                        state <= S_FRAME;
                    end
                end
                S_FRAME: begin
                    if (frame_done) begin
                        if (!frame_ok) begin
                            state <= S_IDLE;
                        end else begin
                            addr_q    <= frame.addr;
                            burst_q   <= frame.burst;
                            delay_cnt <= '0;
                            if (frame.write) begin
                                state <= S_WRITE;
                            end else begin
                                ready <= 1'b0;
                                state <= (`SLAVE_ACCESS_DELAY == 0) ? S_FETCH : S_DELAY;
                            end
                        end
                    end
                end
                S_DELAY: begin
                    if (delay_cnt == DLY_LAST) begin
                        state <= S_FETCH;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                S_FETCH: begin
                    ready <= 1'b1;
                    state <= S_SEND;
                end
                S_SEND: begin
                    if (last) begin
                        last_q <= 1'b1;
                    end
                    if (word_done) begin
                        addr_q <= addr_q + 1'b1;
                        last_q <= 1'b0;
                        if (!burst_q || last_q || last) begin
                            state <= S_IDLE;
                        end else begin
                            // one fetch cycle with ready low
                            ready <= 1'b0;
                            state <= S_FETCH;
                        end
                    end
                end
                S_WRITE: begin
                    if (last) begin
                        last_q <= 1'b1;
                    end
                    if (wr_done) begin
                        // this cycle may already carry the next word
                        last_q <= last;
                        if (!burst_q || last_q) begin
                            state <= S_IDLE;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign frame_shift = ((state == S_IDLE) && control) || ((state == S_FRAME) && !frame_done);
    assign frame_clear = (state == S_IDLE) && !control;
    assign wr_shift    = (state == S_WRITE) && valid;
    assign rd_load     = (state == S_FETCH);
    assign rd_shift    = (state == S_SEND);

    // prefetch the next burst address during a word
    assign rd_addr = (state == S_SEND) ? word_addr_t'(addr_q + 1'b1) : addr_q;

    always_comb begin
        mem_wr.en   = (state == S_WRITE) && wr_done;
        mem_wr.addr = addr_q;
        mem_wr.data = wr_word;
    end

endmodule

`default_nettype wire

//--- hw/serial_slave.sv
// ####################
// serial bus slave top level
// instantiate with its SLAVE_ID
// ####################
`timescale 1ns/10ps
`default_nettype none

`include "serial_slave_defines.svh"

module serial_slave #(
    parameter serial_slave_pkg::slave_id_t SLAVE_ID = `SLAVE_DEFAULT_ID
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);

    import serial_slave_pkg::*;

    cmd_frame_t frame;
    logic       frame_done;
    logic       frame_shift;
    logic       frame_clear;
    data_word_t wr_word;
    logic       wr_done;
    logic       wr_shift;
    logic       rd_load;
    logic       rd_shift;
    logic       rd_bit;
    logic       word_done;
    mem_write_t mem_wr;
    word_addr_t rd_addr;
    data_word_t rd_data;

    serial_deserializer #(
        .payload_t(cmd_frame_t)
    ) frame_deser (
        .clk      (clk),
        .rstN     (rstN),
        .shift_en (frame_shift),
        .bit_in   (control),
        .clear    (frame_clear),
        .payload  (frame),
        .done     (frame_done)
    );

    // write word count also restarts while idle
    serial_deserializer #(
        .payload_t(data_word_t)
    ) wr_deser (
        .clk      (clk),
        .rstN     (rstN),
        .shift_en (wr_shift),
        .bit_in   (wD),
        .clear    (frame_clear),
        .payload  (wr_word),
        .done     (wr_done)
    );

    word_serializer rd_ser (
        .clk       (clk),
        .rstN      (rstN),
        .load      (rd_load),
        .word      (rd_data),
        .shift_en  (rd_shift),
        .bit_out   (rd_bit),
        .word_done (word_done)
    );

    slave_memory mem (
        .clk     (clk),
        .wr      (mem_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    slave_controller #(
        .SLAVE_ID(SLAVE_ID)
    ) ctrl (
        .clk         (clk),
        .rstN        (rstN),
        .control     (control),
        .valid       (valid),
        .last        (last),
        .frame       (frame),
        .frame_done  (frame_done),
        .wr_done     (wr_done),
        .word_done   (word_done),
        .wr_word     (wr_word),
        .frame_shift (frame_shift),
        .frame_clear (frame_clear),
        .wr_shift    (wr_shift),
        .rd_load     (rd_load),
        .rd_shift    (rd_shift),
        .ready       (ready),
        .mem_wr      (mem_wr),
        .rd_addr     (rd_addr)
    );

    // line stays low outside a word
    assign rD = rd_bit & rd_shift;

endmodule

`default_nettype wire

//--- verif/serial_slave_assertions.sv
// ####################
// port properties of the serial slave bound into each instance
// ####################
`timescale 1ns/10ps
`default_nettype none

module serial_slave_assertions (
    input logic                         clk,
    input logic                         rstN,
    input logic                         ready,
    input logic                         rD,
    input logic                         wr_shift,
    input serial_slave_pkg::mem_write_t mem_wr
);

    int fail_count = 0;

    // idle level right out of reset
    ready_after_reset: assert property (@(posedge clk) $rose(rstN) |-> ready)
        else begin
            fail_count++;
            $error("ready low on the first edge after reset");
        end

    rd_low_when_busy: assert property (@(posedge clk) disable iff (!rstN) !ready |-> !rD)
        else begin
            fail_count++;
            $error("rD high while ready is low");
        end

    // write bits and stores only with ready high
    ready_held_in_write: assert property (@(posedge clk) disable iff (!rstN)
        (wr_shift || mem_wr.en) |-> ready)
        else begin
            fail_count++;
            $error("ready fell during a write");
        end

endmodule

bind serial_slave serial_slave_assertions port_checks (
    .clk      (clk),
    .rstN     (rstN),
    .ready    (ready),
    .rD       (rD),
    .wr_shift (wr_shift),
    .mem_wr   (mem_wr)
);

`default_nettype wire

//--- verif/serial_slave_tb.sv
// ####################
// testbench that runs the stimulus table against the serial slave DUT
// ####################
`timescale 1ns/10ps
`default_nettype none

`include "serial_slave_defines.svh"

module serial_slave_tb;

    import serial_slave_pkg::*;

    localparam int        CLK_PERIOD     = 100;
    localparam int        SEED           = 53815;
    localparam int        NUM_TESTS      = 8;
    localparam int        MAX_WORDS      = 4;
    localparam int        QUIET_CYCLES   = 40;
    localparam int        CYCLES_PER_WORD = 200;
    localparam slave_id_t DUT_ID         = 2'd1;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    // stimulus table with one entry per test in every column
    string      test_name [NUM_TESTS];
    logic [2:0] start_code[NUM_TESTS];
    slave_id_t  test_id   [NUM_TESTS];
    logic       is_write  [NUM_TESTS];
    logic       is_burst  [NUM_TESTS];
    word_addr_t test_addr [NUM_TESTS];
    int         word_count[NUM_TESTS];
    // data sent by a write or expected from a read
    data_word_t test_words[NUM_TESTS][MAX_WORDS];

    int errors = 0;
    int checks = 0;
    int limit_cycles = 0;

    serial_slave #(
        .SLAVE_ID(DUT_ID)
    ) serial_slave_inst (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_word(input string name, input data_word_t expected,
                              input data_word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s ready: expected %b, actual %b at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic check_rd_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s rD: expected %b, actual %b at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic set_row(input int i, input string name, input logic [2:0] code,
                           input slave_id_t id, input logic wr, input logic burst,
                           input word_addr_t addr, input int n);
        test_name[i]  = name;
        start_code[i] = code;
        test_id[i]    = id;
        is_write[i]   = wr;
        is_burst[i]   = burst;
        test_addr[i]  = addr;
        word_count[i] = n;
    endtask

    task automatic build_table();
        data_word_t single_word;
        data_word_t burst_word[MAX_WORDS];
        single_word = $urandom;
        for (int k = 0; k < MAX_WORDS; k++) begin
            burst_word[k] = $urandom;
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            for (int k = 0; k < MAX_WORDS; k++) begin
                test_words[i][k] = '0;
            end
        end
        //      row name            code    id    wr    burst addr     n
        set_row(0, "single_write", 3'b111, 2'd1, 1'b1, 1'b0, 11'd12,  1);
        set_row(1, "single_read",  3'b111, 2'd1, 1'b0, 1'b0, 11'd12,  1);
        set_row(2, "burst_write",  3'b111, 2'd1, 1'b1, 1'b1, 11'd100, 4);
        set_row(3, "burst_read",   3'b111, 2'd1, 1'b0, 1'b1, 11'd100, 4);
        set_row(4, "burst_stop",   3'b111, 2'd1, 1'b0, 1'b1, 11'd100, 2);
        set_row(5, "bad_id_write", 3'b111, 2'd2, 1'b1, 1'b0, 11'd12,  1);
        set_row(6, "bad_id_check", 3'b111, 2'd1, 1'b0, 1'b0, 11'd12,  1);
        set_row(7, "bad_start",    3'b110, 2'd1, 1'b0, 1'b0, 11'd12,  1);
        test_words[0][0] = single_word;
        test_words[1][0] = single_word;
        for (int k = 0; k < MAX_WORDS; k++) begin
            test_words[2][k] = burst_word[k];
            test_words[3][k] = burst_word[k];
        end
        test_words[4][0] = burst_word[0];
        test_words[4][1] = burst_word[1];
        // must never reach the memory
        test_words[5][0] = ~single_word;
        test_words[6][0] = single_word;
    endtask

    // frame MSB first on control
    task automatic send_frame(input int t, input cmd_frame_t f);
        for (int i = $bits(cmd_frame_t) - 1; i >= 0; i--) begin
            @(posedge clk);
            control <= f[i];
            @(negedge clk);
            check_ready(test_name[t], 1'b1, ready);
        end
        @(posedge clk);
        control <= 1'b0;
    endtask

    task automatic write_words(input int t);
        data_word_t word;
        for (int w = 0; w < word_count[t]; w++) begin
            word = test_words[t][w];
            for (int b = $bits(data_word_t) - 1; b >= 0; b--) begin
                // random pauses in valid
                while ($urandom_range(3) == 0) begin
                    @(posedge clk);
                    valid <= 1'b0;
                end
                @(posedge clk);
                valid <= 1'b1;
                wD    <= word[b];
                last  <= is_burst[t] && (w == word_count[t] - 1);
            end
        end
        @(posedge clk);
        valid <= 1'b0;
        wD    <= 1'b0;
        last  <= 1'b0;
    endtask

    // every ready-high cycle after the first ready drop carries a bit
    task automatic read_words(input int t);
        data_word_t cur;
        int         nbits;
        int         w;
        logic       seen_low;
        cur      = '0;
        nbits    = 0;
        w        = 0;
        seen_low = 1'b0;
        while (w < word_count[t]) begin
            @(posedge clk);
            last <= is_burst[t] && (w == word_count[t] - 1);
            @(negedge clk);
            if (!ready) begin
                seen_low = 1'b1;
            end else if (seen_low) begin
                cur = (cur << 1) | data_word_t'(rD);
                nbits++;
                if (nbits == $bits(data_word_t)) begin
                    check_word($sformatf("%s word %0d", test_name[t], w),
                               test_words[t][w], cur);
                    w++;
                    nbits = 0;
                end
            end
        end
        @(posedge clk);
        last <= 1'b0;
    endtask

    task automatic check_quiet(input int t);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_ready(test_name[t], 1'b1, ready);
            check_rd_bit(test_name[t], 1'b0, rD);
        end
    endtask

    task automatic run_test(input int t);
        cmd_frame_t f;
        logic       accepted;
        f.start_code = start_code[t];
        f.slave_id   = test_id[t];
        f.write      = is_write[t];
        f.burst      = is_burst[t];
        f.addr       = test_addr[t];
        accepted     = (start_code[t] == `SLAVE_START_CODE) && (test_id[t] == DUT_ID);
        send_frame(t, f);
        if (is_write[t]) begin
            write_words(t);
        end else if (accepted) begin
            read_words(t);
        end
        check_quiet(t);
    endtask

    // watchdog
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", limit_cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int total_words;
        int assert_fails;
        rstN    = 1'b0;
        control = 1'b0;
        wD      = 1'b0;
        valid   = 1'b0;
        last    = 1'b0;
        void'($urandom(SEED));
        build_table();
        total_words = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total_words += word_count[i];
        end
        limit_cycles = total_words * CYCLES_PER_WORD;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        assert_fails = serial_slave_inst.port_checks.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- serial_slave.f
+incdir+hw
hw/serial_slave_pkg.sv
hw/serial_deserializer.sv
hw/word_serializer.sv
hw/slave_memory.sv
hw/slave_controller.sv
hw/serial_slave.sv
verif/serial_slave_assertions.sv
verif/serial_slave_tb.sv

//--- Makefile
# Verilator build and run of the serial slave testbench

VERILATOR ?= verilator
TOP       ?= serial_slave_tb
FILELIST  ?= serial_slave.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
SIMFLAGS  ?= +verilator+error+limit+100

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(FILELIST) $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN) $(SIMFLAGS))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
